//--- dv/system_controller_chk.sv
`timescale 1ns/1ps

module system_controller_chk (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  system_start,
    input logic                  system_pause,
    input logic                  error_ack,
    input sysctl_pkg::recovery_t recovery_action
);

    int fail_count = 0;    // failed assertions so far

    // start and pause are mutually exclusive
    start_pause_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(system_start && system_pause))
        else begin
            fail_count++;
            $error("system_start and system_pause high together");
        end

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(error_ack) |=> !error_ack)
        else begin
            fail_count++;
            $error("error_ack held longer than one cycle");
        end

    // codes 0..6 and 15 only
    action_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (recovery_action <= 4'd6) || (recovery_action == 4'd15))
        else begin
            fail_count++;
            $error("recovery_action outside the legal set");
        end

endmodule

bind system_controller system_controller_chk chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .system_start    (system_start),
    .system_pause    (system_pause),
    .error_ack       (error_ack),
    .recovery_action (recovery_action)
);

//--- dv/system_controller_tb.sv
`timescale 1ns/1ps

module system_controller_tb;
    import sysctl_pkg::*;

    // budget per phase in cycles
    localparam int RESET_BUDGET  = 30;
    localparam int STATUS_BUDGET = 30;
    localparam int TUNE_BUDGET   = 12 * 12;
    localparam int ERROR_BUDGET  = 6 * 45;
    localparam int CONFIG_BUDGET = 4 * 30;
    localparam int CYCLE_LIMIT   = RESET_BUDGET + STATUS_BUDGET + TUNE_BUDGET
                                   + ERROR_BUDGET + CONFIG_BUDGET + 200;

    logic clk = 1'b0;
    logic rst_n;
    logic [31:0] config_reg;
    logic config_valid;
    logic engine_busy, scheduler_busy, convergence_done;
    logic [7:0] iteration_count;
    logic [15:0] metric_util, metric_load, metric_idle, metric_eff, metric_conv;
    logic error_detected;
    err_code_t error_code;
    logic system_ready;
    logic [31:0] status_reg;
    logic [31:0] error_history;
    engine_mode_t engine_mode;
    sched_mode_t scheduler_mode;
    conv_mode_t convergence_mode;
    logic redundancy_enable, stealing_enable;
    logic error_ack, system_reset, system_pause, system_start;
    recovery_t recovery_action;

    logic [31:0] rng_state = 32'h7718f47b;
    int cycle_count = 0;

    // reference model
    engine_mode_t cfg_eng, exp_eng;
    sched_mode_t cfg_sch, exp_sch;
    conv_mode_t cfg_cnv, exp_cnv;
    logic cfg_red, cfg_stl, exp_red, exp_stl;
    perf_t cfg_tgt;
    logic [31:0] hist = '0;
    int hptr = 0;
    int retries = 0;

    system_controller DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("simulation ran past its cycle budget without finishing");
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "mismatch");
    endtask

    task automatic check_eng(input string name, input engine_mode_t got, input engine_mode_t exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_sch(input string name, input sched_mode_t got, input sched_mode_t exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_cnv(input string name, input conv_mode_t got, input conv_mode_t exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_rec(input string name, input recovery_t got, input recovery_t exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) report_value(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_modes();
        check_eng("engine_mode", engine_mode, exp_eng);
        check_sch("scheduler_mode", scheduler_mode, exp_sch);
        check_cnv("convergence_mode", convergence_mode, exp_cnv);
        check_bit("redundancy_enable", redundancy_enable, exp_red);
        check_bit("stealing_enable", stealing_enable, exp_stl);
    endtask

    task automatic take_cfg_as_modes();
        exp_eng = cfg_eng;
        exp_sch = cfg_sch;
        exp_cnv = cfg_cnv;
        exp_red = cfg_red;
        exp_stl = cfg_stl;
    endtask

    task automatic zero_modes();
        exp_eng = ENG_OFF;
        exp_sch = SCH_STOP;
        exp_cnv = CONV_STRICT;
        exp_red = 1'b0;
        exp_stl = 1'b0;
    endtask

    function automatic logic [31:0] make_cfg(input logic [2:0] flags);
        logic [31:0] w;
        w = next_rand();
        w[15:11] = 5'((next_rand() % 31) + 1);    // nonzero target
        w[18:16] = flags;
        return w;
    endfunction

    // one-cycle config_valid strobe and model update
    task automatic send_cfg(input logic [31:0] w);
        @(negedge clk);
        config_reg = w;
        config_valid = 1'b1;
        @(negedge clk);
        config_valid = 1'b0;
        cfg_eng = engine_mode_t'(w[3:0]);
        cfg_sch = sched_mode_t'(w[6:4]);
        cfg_cnv = conv_mode_t'(w[8:7]);
        cfg_red = w[9];
        cfg_stl = w[10];
        cfg_tgt = 8'(w[15:11] * 5);
        retries = 0;
    endtask

    // returns how long system_start stayed high
    task automatic wait_start_pulse(output int len);
        int n;
        n = 0;
        while (system_start !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 40) stop_fail("system_start never went high");
        end
        len = 0;
        while (system_start === 1'b1) begin
            @(negedge clk);
            len++;
            if (len > 40) stop_fail("system_start stuck high");
        end
    endtask

    task automatic wait_pause(input logic level);
        int n;
        n = 0;
        while (system_pause !== level) begin
            @(negedge clk);
            n++;
            if (n > 40) stop_fail("system_pause did not reach the expected level");
        end
    endtask

    task automatic set_metrics(input logic healthy);
        metric_util = healthy ? 16'd9000 : 16'd100;
        metric_load = healthy ? 16'd8000 : 16'd100;
        metric_idle = healthy ? 16'd500 : 16'd9000;
        metric_conv = healthy ? 16'd10 : 16'd900;
    endtask

    task automatic do_tune();
        int perf;
        int gap;
        perf = int'(next_rand() % 32'(cfg_tgt));
        gap = int'(cfg_tgt) - perf;
        metric_eff = 16'(perf * 100 + int'(next_rand() % 100));
        @(negedge clk);
        set_metrics(1'b1);
        @(negedge clk);    // now in TUNE
        @(negedge clk);    // modes set from the gap
        set_metrics(1'b0);
        if (gap > 20) begin
            exp_eng = ENG_HIGH;
            exp_sch = SCH_AGGR;
            exp_cnv = CONV_FAST;
        end else if (gap > 10) begin
            exp_eng = ENG_BALANCED;
            exp_sch = SCH_BALANCED;
        end else begin
            exp_eng = ENG_NORMAL;
            exp_sch = SCH_CONSERV;
        end
        check_modes();
        repeat (5) @(negedge clk);
        check_modes();
    endtask

    task automatic do_error(input err_code_t code);
        int n;
        recovery_t act;
        act = (code >= 4'd1 && code <= 4'd6) ? recovery_t'(code) : REC_UNKNOWN;
        error_detected = 1'b1;
        error_code = code;
        @(negedge clk);
        error_detected = 1'b0;
        check_rec("recovery_action", recovery_action, act);
        hist[hptr*4 +: 4] = code;
        hptr = (hptr + 1) % 8;
        check_word("error_history", error_history, hist);
        n = 0;
        if (retries < 3) begin
            while (error_ack !== 1'b1) begin
                @(negedge clk);
                n++;
                // restart action pulses reset in recovery step 3
                check_bit("system_reset", system_reset, act == REC_RESTART && n == 15);
                if (n > 40) stop_fail("error_ack never pulsed after an error");
            end
            check_word("error_ack delay", 32'(n), 32'd17);
            retries++;
            take_cfg_as_modes();
            wait_start_pulse(n);
            check_modes();
        end else begin
            repeat (12) begin
                @(negedge clk);
                if (error_ack === 1'b1) stop_fail("error_ack pulsed although retries ran out");
            end
            zero_modes();
            check_modes();
        end
    endtask

    initial begin
        int len;
        logic [31:0] w;
        logic [31:0] st;
        rst_n = 1'b0;
        config_reg = '0;
        config_valid = 1'b0;
        engine_busy = 1'b0;
        scheduler_busy = 1'b0;
        convergence_done = 1'b0;
        iteration_count = '0;
        metric_eff = 16'd5000;
        set_metrics(1'b0);
        error_detected = 1'b0;
        error_code = '0;
        system_ready = 1'b0;
        cfg_eng = ENG_NORMAL;
        cfg_sch = SCH_BALANCED;
        cfg_cnv = CONV_ADAPTIVE;
        cfg_red = 1'b1;
        cfg_stl = 1'b1;
        cfg_tgt = 8'd80;
        take_cfg_as_modes();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_modes();
        check_bit("system_start", system_start, 1'b0);
        check_rec("recovery_action", recovery_action, REC_NONE);

        system_ready = 1'b1;
        @(negedge clk);
        system_ready = 1'b0;
        wait_start_pulse(len);
        check_word("system_start length", 32'(len), 32'd16);
        check_modes();

        // status fields one cycle after the inputs
        repeat (20) begin
            w = next_rand();
            engine_busy = w[0];
            scheduler_busy = w[1];
            convergence_done = w[2];
            error_code = w[7:4];
            iteration_count = w[15:8];
            @(negedge clk);
            st = {8'(metric_eff / 100), 4'h0, 4'd3, w[15:8], w[7:4], 1'b0, w[2:0]};
            check_word("status_reg", status_reg, st);
        end

        repeat (6) do_tune();

        // three recoveries and then a shutdown
        repeat (4) do_error(err_code_t'(next_rand()));

        send_cfg(make_cfg(3'b001));
        take_cfg_as_modes();
        wait_start_pulse(len);
        check_modes();
        wait_pause(1'b1);
        check_bit("system_start", system_start, 1'b0);
        send_cfg(make_cfg(3'b100));
        wait_pause(1'b0);
        @(negedge clk);
        zero_modes();
        check_modes();

        send_cfg(make_cfg(3'b001));
        take_cfg_as_modes();
        wait_start_pulse(len);
        check_modes();
        wait_pause(1'b1);
        send_cfg(make_cfg({next_rand() % 2 == 0, 2'b10}));    // resume wins
        wait_pause(1'b0);
        take_cfg_as_modes();
        check_modes();
        @(negedge clk);

        do_error(err_code_t'(4'd3));
        do_error(err_code_t'(next_rand()));
        repeat (6) do_tune();

        if (DUT.chk.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertions failed");
        end
    end

endmodule

//--- files.f
+incdir+source
source/sysctl_pkg.sv
source/sysctl_config.sv
source/sysctl_health.sv
source/sysctl_error_log.sv
source/sysctl_sequencer.sv
source/system_controller.sv
dv/system_controller_chk.sv
dv/system_controller_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module system_controller_tb --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- source/sysctl_config.sv
`timescale 1ns/1ps
`include "sysctl_params.svh"

module sysctl_config (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               config_reg,
    input  logic                      cfg_load,
    input  logic                      cmd_taken,
    output sysctl_pkg::engine_mode_t  cfg_engine,
    output sysctl_pkg::sched_mode_t   cfg_sched,
    output sysctl_pkg::conv_mode_t    cfg_conv,
    output logic                      cfg_redundancy,
    output logic                      cfg_stealing,
    output sysctl_pkg::perf_t         perf_target,
    output logic                      cmd_pause,
    output logic                      cmd_resume,
    output logic                      cmd_shutdown
);
    import sysctl_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_engine     <= engine_mode_t'(`SYSCTL_DEF_ENGINE);
            cfg_sched      <= sched_mode_t'(`SYSCTL_DEF_SCHED);
            cfg_conv       <= conv_mode_t'(`SYSCTL_DEF_CONV);
            cfg_redundancy <= `SYSCTL_DEF_REDUND;
            cfg_stealing   <= `SYSCTL_DEF_STEAL;
            perf_target    <= perf_t'(`SYSCTL_DEF_TARGET);
        end else if (cfg_load) begin
            cfg_engine     <= engine_mode_t'(config_reg[3:0]);
            cfg_sched      <= sched_mode_t'(config_reg[6:4]);
            cfg_conv       <= conv_mode_t'(config_reg[8:7]);
            cfg_redundancy <= config_reg[9];
            cfg_stealing   <= config_reg[10];
            perf_target    <= perf_t'(config_reg[15:11]) * perf_t'(`SYSCTL_TARGET_SCALE);
        end
    end

    // flags live until the sequencer acts on one of them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {cmd_shutdown, cmd_resume, cmd_pause} <= 3'b000;
        end else if (cfg_load) begin
            {cmd_shutdown, cmd_resume, cmd_pause} <= config_reg[18:16];
        end else if (cmd_taken) begin
            {cmd_shutdown, cmd_resume, cmd_pause} <= 3'b000;
        end
    end

endmodule

//--- source/sysctl_error_log.sv
`timescale 1ns/1ps
`include "sysctl_params.svh"

module sysctl_error_log (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               err_record,
    input  sysctl_pkg::err_code_t              error_code,
    input  logic                               retry_inc,
    input  logic                               cfg_load,
    output logic [4*`SYSCTL_HIST_DEPTH-1:0]    error_history,
    output logic [1:0]                         retry_count
);

    localparam int PTR_W = $clog2(`SYSCTL_HIST_DEPTH);

    logic [PTR_W-1:0] wr_ptr;

    // nibble i holds entry i, pointer wraps on its own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_history <= '0;
            wr_ptr        <= '0;
        end else if (err_record) begin
            error_history[wr_ptr*4 +: 4] <= error_code;
            wr_ptr                       <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retry_count <= '0;
        end else if (cfg_load) begin
            retry_count <= '0;    // fresh config, fresh budget
        end else if (retry_inc && retry_count != 2'b11) begin
            retry_count <= retry_count + 1'b1;
        end
    end

endmodule

//--- source/sysctl_health.sv
`timescale 1ns/1ps
`include "sysctl_params.svh"

module sysctl_health (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [15:0]       metric_util,
    input  logic [15:0]       metric_load,
    input  logic [15:0]       metric_idle,
    input  logic [15:0]       metric_eff,
    input  logic [15:0]       metric_conv,
    input  sysctl_pkg::perf_t perf_target,
    output sysctl_pkg::perf_t current_performance,
    output logic              tune_req
);

    logic       util_ok;
    logic       load_ok;
    logic       idle_ok;
    logic       conv_ok;
    logic [2:0] hits;

    assign util_ok = metric_util > 16'(`SYSCTL_UTIL_THRESH);
    assign load_ok = metric_load > 16'(`SYSCTL_LOAD_THRESH);
    assign idle_ok = metric_idle < 16'(`SYSCTL_IDLE_THRESH);
    assign conv_ok = metric_conv < 16'(`SYSCTL_CONV_THRESH);

    assign hits = 3'(util_ok) + 3'(load_ok) + 3'(idle_ok) + 3'(conv_ok);

    // healthy but short of target
    assign tune_req = (hits >= 3'd3) && (current_performance < perf_target);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_performance <= '0;
        end else begin
            current_performance <= 8'(metric_eff / 16'(`SYSCTL_PERF_DIV)); // truncated
        end
    end

endmodule

//--- source/sysctl_params.svh
`ifndef SYSCTL_PARAMS_SVH
`define SYSCTL_PARAMS_SVH

// phase lengths in cycles
`define SYSCTL_INIT_CYCLES    16
`define SYSCTL_ERROR_HOLD     11
`define SYSCTL_RECOVER_STEPS  6
`define SYSCTL_TUNE_STEPS     5
`define SYSCTL_MAX_RETRIES    3

// metric thresholds, hundredths of a percent
`define SYSCTL_UTIL_THRESH    8000
`define SYSCTL_LOAD_THRESH    7000
`define SYSCTL_IDLE_THRESH    2000
`define SYSCTL_CONV_THRESH    30
`define SYSCTL_PERF_DIV       100

`define SYSCTL_TARGET_SCALE   5
`define SYSCTL_HIST_DEPTH     8

// values seen before any configuration
`define SYSCTL_DEF_ENGINE     1
`define SYSCTL_DEF_SCHED      2
`define SYSCTL_DEF_CONV       1
`define SYSCTL_DEF_REDUND     1'b1
`define SYSCTL_DEF_STEAL      1'b1
`define SYSCTL_DEF_TARGET     80

`endif

//--- source/sysctl_pkg.sv
package sysctl_pkg;

    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        CONFIG   = 4'd1,
        INIT     = 4'd2,
        RUN      = 4'd3,
        PAUSE    = 4'd4,
        RECOVER  = 4'd5,
        SHUTDOWN = 4'd6,
        ERROR    = 4'd7,
        TUNE     = 4'd9
    } sys_state_t;

    typedef enum logic [3:0] {
        ENG_OFF      = 4'd0,
        ENG_NORMAL   = 4'd1,
        ENG_BALANCED = 4'd2,
        ENG_HIGH     = 4'd3
    } engine_mode_t;

    typedef enum logic [2:0] {
        SCH_STOP     = 3'd0,
        SCH_CONSERV  = 3'd1,
        SCH_BALANCED = 3'd2,
        SCH_AGGR     = 3'd4
    } sched_mode_t;

    typedef enum logic [1:0] {
        CONV_STRICT   = 2'd0,
        CONV_ADAPTIVE = 2'd1,
        CONV_FAST     = 2'd2
    } conv_mode_t;

    // codes 1..6 follow the error code that caused them
    typedef enum logic [3:0] {
        REC_NONE    = 4'd0,
        REC_ITER    = 4'd1,
        REC_CONV    = 4'd2,
        REC_RESTART = 4'd3,
        REC_CHECK   = 4'd4,
        REC_DRAIN   = 4'd5,
        REC_HOLD    = 4'd6,
        REC_UNKNOWN = 4'd15
    } recovery_t;

    typedef logic [7:0] perf_t;
    typedef logic [3:0] err_code_t;

endpackage

//--- source/sysctl_sequencer.sv
`timescale 1ns/1ps
`include "sysctl_params.svh"

module sysctl_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      config_valid,
    input  logic                      system_ready,
    input  logic                      error_detected,
    input  sysctl_pkg::err_code_t     error_code,
    input  sysctl_pkg::engine_mode_t  cfg_engine,
    input  sysctl_pkg::sched_mode_t   cfg_sched,
    input  sysctl_pkg::conv_mode_t    cfg_conv,
    input  logic                      cfg_redundancy,
    input  logic                      cfg_stealing,
    input  logic                      cmd_pause,
    input  logic                      cmd_resume,
    input  logic                      cmd_shutdown,
    input  logic                      tune_req,
    input  sysctl_pkg::perf_t         current_performance,
    input  sysctl_pkg::perf_t         perf_target,
    input  logic [1:0]                retry_count,
    input  logic                      engine_busy,
    input  logic                      scheduler_busy,
    input  logic                      convergence_done,
    input  logic [7:0]                iteration_count,
    output logic                      cfg_load,
    output logic                      cmd_taken,
    output logic                      err_record,
    output logic                      retry_inc,
    output sysctl_pkg::engine_mode_t  engine_mode,
    output sysctl_pkg::sched_mode_t   scheduler_mode,
    output sysctl_pkg::conv_mode_t    convergence_mode,
    output logic                      redundancy_enable,
    output logic                      stealing_enable,
    output sysctl_pkg::recovery_t     recovery_action,
    output logic                      error_ack,
    output logic                      system_reset,
    output logic                      system_pause,
    output logic                      system_start,
    output logic [31:0]               status_reg
);
    import sysctl_pkg::*;

    sys_state_t        state;
    sys_state_t        next_state;
    logic [3:0]        cnt;         // cycles spent in the current state
    logic              reload;
    logic signed [9:0] gap;

    function automatic recovery_t map_recovery(input err_code_t code);
        if (code >= 4'd1 && code <= 4'd6)
            return recovery_t'(code);
        return REC_UNKNOWN;
    endfunction

    assign gap = $signed({2'b00, perf_target}) - $signed({2'b00, current_performance});

    always_comb begin
        next_state = state;
        cfg_load   = 1'b0;
        cmd_taken  = 1'b0;
        err_record = 1'b0;
        retry_inc  = 1'b0;
        case (state)
            IDLE: begin
                if (config_valid)      next_state = CONFIG;
                else if (system_ready) next_state = INIT;
            end
            CONFIG: begin
                cfg_load   = 1'b1;
                next_state = INIT;
            end
            INIT: if (cnt == 4'(`SYSCTL_INIT_CYCLES - 1)) next_state = RUN;
            RUN: begin
                if (error_detected) begin
                    err_record = 1'b1;
                    next_state = ERROR;
                end else if (cmd_pause) begin
                    cmd_taken  = 1'b1;
                    next_state = PAUSE;
                end else if (tune_req) begin
                    next_state = TUNE;
                end
            end
            PAUSE: begin
                if (config_valid) begin
                    cfg_load = 1'b1;    // stay paused, take new word
                end else if (cmd_resume) begin
                    cmd_taken  = 1'b1;
                    next_state = RUN;
                end else if (cmd_shutdown) begin
                    cmd_taken  = 1'b1;
                    next_state = SHUTDOWN;
                end
            end
            TUNE: if (cnt == 4'(`SYSCTL_TUNE_STEPS - 1)) next_state = RUN;
            ERROR: begin
                if (cnt == 4'(`SYSCTL_ERROR_HOLD - 1)) begin
                    if (retry_count < 2'(`SYSCTL_MAX_RETRIES)) begin
                        retry_inc  = 1'b1;
                        next_state = RECOVER;
                    end else begin
                        next_state = SHUTDOWN;
                    end
                end
            end
            RECOVER: if (cnt == 4'(`SYSCTL_RECOVER_STEPS - 1)) next_state = INIT;
            SHUTDOWN: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // points where the configured modes are copied to the outputs
    assign reload = (state == INIT && cnt == 4'd0) ||
                    (state == RECOVER && cnt == 4'd4) ||
                    (state == PAUSE && next_state == RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= IDLE;
            cnt               <= '0;
            engine_mode       <= engine_mode_t'(`SYSCTL_DEF_ENGINE);
            scheduler_mode    <= sched_mode_t'(`SYSCTL_DEF_SCHED);
            convergence_mode  <= conv_mode_t'(`SYSCTL_DEF_CONV);
            redundancy_enable <= `SYSCTL_DEF_REDUND;
            stealing_enable   <= `SYSCTL_DEF_STEAL;
            recovery_action   <= REC_NONE;
            error_ack         <= 1'b0;
            system_reset      <= 1'b0;
            system_pause      <= 1'b0;
            system_start      <= 1'b0;
            status_reg        <= '0;
        end else begin
            state        <= next_state;
            cnt          <= (next_state != state) ? 4'd0 : cnt + 4'd1;
            system_start <= (next_state == INIT);
            system_reset <= 1'b0;
            error_ack    <= 1'b0;
            if (state != RECOVER)
                system_pause <= (next_state == PAUSE);

            case (state)
                RUN: begin
                    status_reg <= {current_performance, 4'h0, state, iteration_count,
                                   error_code, error_detected, convergence_done,
                                   scheduler_busy, engine_busy};
                    if (error_detected)
                        recovery_action <= map_recovery(error_code);
                end
                TUNE: begin
                    if (cnt == 4'd0) begin
                        if (gap > 10'sd20) begin
                            engine_mode      <= ENG_HIGH;
                            scheduler_mode   <= SCH_AGGR;
                            convergence_mode <= CONV_FAST;
                        end else if (gap > 10'sd10) begin
                            engine_mode    <= ENG_BALANCED;
                            scheduler_mode <= SCH_BALANCED;
                        end else if (gap > 10'sd0) begin
                            engine_mode    <= ENG_NORMAL;
                            scheduler_mode <= SCH_CONSERV;
                        end
                    end
                end
                RECOVER: begin
                    case (cnt)
                        4'd0: system_pause <= 1'b1;
                        4'd1: engine_mode <= ENG_OFF;
                        4'd2: scheduler_mode <= SCH_STOP;
                        4'd3: begin
                            case (recovery_action)
                                REC_CONV:    convergence_mode <= CONV_ADAPTIVE;
                                REC_RESTART: system_reset <= 1'b1;    // single cycle
                                REC_DRAIN:   scheduler_mode <= SCH_CONSERV;
                                REC_HOLD:    system_pause <= 1'b1;
                                default: ;
                            endcase
                        end
                        4'd5: begin
                            system_pause <= 1'b0;
                            error_ack    <= 1'b1;    // leaving for INIT
                        end
                        default: ;
                    endcase
                end
                SHUTDOWN: begin
                    engine_mode       <= ENG_OFF;
                    scheduler_mode    <= SCH_STOP;
                    convergence_mode  <= CONV_STRICT;
                    redundancy_enable <= 1'b0;
                    stealing_enable   <= 1'b0;
                end
                default: ;
            endcase

            if (reload) begin
                engine_mode       <= cfg_engine;
                scheduler_mode    <= cfg_sched;
                convergence_mode  <= cfg_conv;
                redundancy_enable <= cfg_redundancy;
                stealing_enable   <= cfg_stealing;
            end
        end
    end

endmodule

//--- source/system_controller.sv
`timescale 1ns/1ps

module system_controller (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               config_reg,
    input  logic                      config_valid,
    output logic [31:0]               status_reg,
    output sysctl_pkg::engine_mode_t  engine_mode,
    output sysctl_pkg::sched_mode_t   scheduler_mode,
    output sysctl_pkg::conv_mode_t    convergence_mode,
    output logic                      redundancy_enable,
    output logic                      stealing_enable,
    input  logic                      engine_busy,
    input  logic                      scheduler_busy,
    input  logic                      convergence_done,
    input  logic [7:0]                iteration_count,
    input  logic [15:0]               metric_util,
    input  logic [15:0]               metric_load,
    input  logic [15:0]               metric_idle,
    input  logic [15:0]               metric_eff,
    input  logic [15:0]               metric_conv,
    input  logic                      error_detected,
    input  sysctl_pkg::err_code_t     error_code,
    output logic                      error_ack,
    output sysctl_pkg::recovery_t     recovery_action,
    output logic                      system_reset,
    output logic                      system_pause,
    output logic                      system_start,
    input  logic                      system_ready,
    output logic [31:0]               error_history
);
    import sysctl_pkg::*;

    engine_mode_t cfg_engine;
    sched_mode_t  cfg_sched;
    conv_mode_t   cfg_conv;
    logic         cfg_redundancy;
    logic         cfg_stealing;
    perf_t        perf_target;
    perf_t        current_performance;
    logic         cmd_pause;
    logic         cmd_resume;
    logic         cmd_shutdown;
    logic         cfg_load;
    logic         cmd_taken;
    logic         err_record;
    logic         retry_inc;
    logic         tune_req;
    logic [1:0]   retry_count;

    sysctl_config u_config (
        .clk, .rst_n, .config_reg, .cfg_load, .cmd_taken,
        .cfg_engine, .cfg_sched, .cfg_conv, .cfg_redundancy, .cfg_stealing,
        .perf_target, .cmd_pause, .cmd_resume, .cmd_shutdown
    );

    sysctl_health u_health (
        .clk, .rst_n, .metric_util, .metric_load, .metric_idle, .metric_eff,
        .metric_conv, .perf_target, .current_performance, .tune_req
    );

    sysctl_error_log u_error_log (
        .clk, .rst_n, .err_record, .error_code, .retry_inc, .cfg_load,
        .error_history, .retry_count
    );

    sysctl_sequencer u_sequencer (
        .clk, .rst_n, .config_valid, .system_ready, .error_detected, .error_code,
        .cfg_engine, .cfg_sched, .cfg_conv, .cfg_redundancy, .cfg_stealing,
        .cmd_pause, .cmd_resume, .cmd_shutdown, .tune_req, .current_performance,
        .perf_target, .retry_count, .engine_busy, .scheduler_busy, .convergence_done,
        .iteration_count, .cfg_load, .cmd_taken, .err_record, .retry_inc,
        .engine_mode, .scheduler_mode, .convergence_mode, .redundancy_enable,
        .stealing_enable, .recovery_action, .error_ack, .system_reset,
        .system_pause, .system_start, .status_reg
    );

endmodule
